// ==== csr_file.f ====
+incdir+verification
hdl/csr_pkg.sv
hdl/csr_write_decode.sv
hdl/csr_trap_regs.sv
hdl/csr_timer.sv
hdl/csr_scratch_regs.sv
hdl/csr_read_mux.sv
hdl/csr_file.sv
verification/csr_file_tb.sv

// ==== hdl/csr_file.sv ====
`timescale 1ns/1ns

module csr_file (
    input  logic                              clk,
    input  logic                              rst,
    input  csr_pkg::csr_write_t               wport1_i,
    input  csr_pkg::csr_write_t               wport2_i,
    input  logic                              excp_flush_i,
    input  csr_pkg::excp_t                    excp_i,
    input  logic                              ertn_flush_i,
    input  logic [csr_pkg::HW_INT_WIDTH-1:0]  hw_int_i,
    input  logic                              llbit_i,
    input  logic                              llbit_set_i,
    input  csr_pkg::csr_addr_e                raddr_i,
    output csr_pkg::csr_word_t                rdata_o,
    output logic                              has_int_o,
    output logic [1:0]                        plv_o,
    output csr_pkg::csr_word_t                eentry_o,
    output csr_pkg::csr_word_t                era_o,
    output csr_pkg::csr_word_t                tid_o,
    output logic [63:0]                       timer_64_o,
    output logic                              llbit_o
);

    csr_pkg::csr_wr_t   wr;
    csr_pkg::csr_word_t crmd;
    csr_pkg::csr_word_t prmd;
    csr_pkg::csr_word_t ectl;
    csr_pkg::csr_word_t estat;
    csr_pkg::csr_word_t tcfg;
    csr_pkg::csr_word_t tval;
    csr_pkg::csr_word_t cntc;
    csr_pkg::csr_word_t save0;
    csr_pkg::csr_word_t save1;
    csr_pkg::csr_word_t save2;
    csr_pkg::csr_word_t save3;
    csr_pkg::csr_word_t llbctl;
    logic               timer_int;

    csr_write_decode u_decode (
        .wport1_i (wport1_i),
        .wport2_i (wport2_i),
        .wr_o     (wr)
    );

    csr_trap_regs u_trap (
        .clk          (clk),
        .rst          (rst),
        .wr_i         (wr),
        .excp_flush_i (excp_flush_i),
        .ertn_flush_i (ertn_flush_i),
        .excp_i       (excp_i),
        .hw_int_i     (hw_int_i),
        .timer_int_i  (timer_int),
        .plv_o        (plv_o),
        .crmd_o       (crmd),
        .prmd_o       (prmd),
        .ectl_o       (ectl),
        .estat_o      (estat),
        .era_o        (era_o),
        .eentry_o     (eentry_o)
    );

    csr_timer u_timer (
        .clk         (clk),
        .rst         (rst),
        .wr_i        (wr),
        .tid_o       (tid_o),
        .tcfg_o      (tcfg),
        .tval_o      (tval),
        .cntc_o      (cntc),
        .timer_int_o (timer_int),
        .timer_64_o  (timer_64_o)
    );

    csr_scratch_regs u_scratch (
        .clk          (clk),
        .rst          (rst),
        .wr_i         (wr),
        .ertn_flush_i (ertn_flush_i),
        .llbit_i      (llbit_i),
        .llbit_set_i  (llbit_set_i),
        .save0_o      (save0),
        .save1_o      (save1),
        .save2_o      (save2),
        .save3_o      (save3),
        .llbctl_o     (llbctl),
        .llbit_o      (llbit_o)
    );

    csr_read_mux u_rmux (
        .raddr_i   (raddr_i),
        .crmd_i    (crmd),
        .prmd_i    (prmd),
        .ectl_i    (ectl),
        .estat_i   (estat),
        .era_i     (era_o),
        .eentry_i  (eentry_o),
        .save0_i   (save0),
        .save1_i   (save1),
        .save2_i   (save2),
        .save3_i   (save3),
        .llbctl_i  (llbctl),
        .tid_i     (tid_o),
        .tcfg_i    (tcfg),
        .tval_i    (tval),
        .cntc_i    (cntc),
        .rdata_o   (rdata_o),
        .has_int_o (has_int_o)
    );

endmodule

// ==== hdl/csr_pkg.sv ====
package csr_pkg;

    typedef logic [31:0] csr_word_t;

    // csr numbers that remain in this core
    typedef enum logic [13:0] {
        CSR_CRMD   = 14'h000,
        CSR_PRMD   = 14'h001,
        CSR_ECTL   = 14'h004,
        CSR_ESTAT  = 14'h005,
        CSR_ERA    = 14'h006,
        CSR_EENTRY = 14'h00c,
        CSR_SAVE0  = 14'h030,
        CSR_SAVE1  = 14'h031,
        CSR_SAVE2  = 14'h032,
        CSR_SAVE3  = 14'h033,
        CSR_TID    = 14'h040,
        CSR_TCFG   = 14'h041,
        CSR_TVAL   = 14'h042,
        CSR_CNTC   = 14'h043,
        CSR_TICLR  = 14'h044,
        CSR_LLBCTL = 14'h060
    } csr_addr_e;

    // decoded write target
    typedef enum logic [4:0] {
        SEL_NONE,
        SEL_CRMD,
        SEL_PRMD,
        SEL_ECTL,
        SEL_ESTAT,
        SEL_ERA,
        SEL_EENTRY,
        SEL_SAVE0,
        SEL_SAVE1,
        SEL_SAVE2,
        SEL_SAVE3,
        SEL_TID,
        SEL_TCFG,
        SEL_TVAL,
        SEL_CNTC,
        SEL_TICLR,
        SEL_LLBCTL
    } csr_sel_e;

    typedef struct packed {
        logic      we;
        csr_addr_e addr;
        csr_word_t data;
    } csr_write_t;

    typedef struct packed {
        csr_sel_e  sel;
        csr_word_t data;
    } csr_wr_t;

    // msb first, so plv lands in bits 1:0
    typedef struct packed {
        logic [1:0] datm;
        logic [1:0] datf;
        logic       pg;
        logic       da;
        logic       ie;
        logic [1:0] plv;
    } crmd_t;

    typedef struct packed {
        logic       pie;
        logic [1:0] pplv;
    } prmd_t;

    typedef struct packed {
        logic [8:0]  esubcode;
        logic [5:0]  ecode;
        logic [12:0] is;
    } estat_t;

    typedef struct packed {
        logic [5:0] ecode;
        logic [8:0] esubcode;
        csr_word_t  era;
    } excp_t;

    localparam csr_word_t CRMD_RESET = 32'h0000_0008;

    localparam int TCFG_EN_BIT       = 0;
    localparam int TCFG_PERIODIC_BIT = 1;
    localparam int TCFG_INITVAL_LSB  = 2;
    localparam int TICLR_CLR_BIT     = 0;
    localparam int LLBCTL_WCLLB_BIT  = 1;
    localparam int LLBCTL_KLO_BIT    = 2;
    localparam int EENTRY_ALIGN_BITS = 6;
    localparam int TIMER_IS_BIT      = 11;
    localparam int HW_INT_WIDTH      = 8;

endpackage

// ==== hdl/csr_read_mux.sv ====
`timescale 1ns/1ns

module csr_read_mux (
    input  csr_pkg::csr_addr_e raddr_i,
    input  csr_pkg::csr_word_t crmd_i,
    input  csr_pkg::csr_word_t prmd_i,
    input  csr_pkg::csr_word_t ectl_i,
    input  csr_pkg::csr_word_t estat_i,
    input  csr_pkg::csr_word_t era_i,
    input  csr_pkg::csr_word_t eentry_i,
    input  csr_pkg::csr_word_t save0_i,
    input  csr_pkg::csr_word_t save1_i,
    input  csr_pkg::csr_word_t save2_i,
    input  csr_pkg::csr_word_t save3_i,
    input  csr_pkg::csr_word_t llbctl_i,
    input  csr_pkg::csr_word_t tid_i,
    input  csr_pkg::csr_word_t tcfg_i,
    input  csr_pkg::csr_word_t tval_i,
    input  csr_pkg::csr_word_t cntc_i,
    output csr_pkg::csr_word_t rdata_o,
    output logic               has_int_o
);

    csr_pkg::crmd_t crmd;

    assign crmd = csr_pkg::crmd_t'(crmd_i[8:0]);

    // ticlr always reads as zero
    always_comb begin
        case (raddr_i)
            csr_pkg::CSR_CRMD:   rdata_o = crmd_i;
            csr_pkg::CSR_PRMD:   rdata_o = prmd_i;
            csr_pkg::CSR_ECTL:   rdata_o = ectl_i;
            csr_pkg::CSR_ESTAT:  rdata_o = estat_i;
            csr_pkg::CSR_ERA:    rdata_o = era_i;
            csr_pkg::CSR_EENTRY: rdata_o = eentry_i;
            csr_pkg::CSR_SAVE0:  rdata_o = save0_i;
            csr_pkg::CSR_SAVE1:  rdata_o = save1_i;
            csr_pkg::CSR_SAVE2:  rdata_o = save2_i;
            csr_pkg::CSR_SAVE3:  rdata_o = save3_i;
            csr_pkg::CSR_LLBCTL: rdata_o = llbctl_i;
            csr_pkg::CSR_TID:    rdata_o = tid_i;
            csr_pkg::CSR_TCFG:   rdata_o = tcfg_i;
            csr_pkg::CSR_TVAL:   rdata_o = tval_i;
            csr_pkg::CSR_CNTC:   rdata_o = cntc_i;
            default:             rdata_o = '0;
        endcase
    end

    // enabled and pending, gated by global ie
    assign has_int_o = (|(ectl_i[12:0] & estat_i[12:0])) & crmd.ie;

endmodule

// ==== hdl/csr_scratch_regs.sv ====
`timescale 1ns/1ns

module csr_scratch_regs (
    input  logic               clk,
    input  logic               rst,
    input  csr_pkg::csr_wr_t   wr_i,
    input  logic               ertn_flush_i,
    input  logic               llbit_i,
    input  logic               llbit_set_i,
    output csr_pkg::csr_word_t save0_o,
    output csr_pkg::csr_word_t save1_o,
    output csr_pkg::csr_word_t save2_o,
    output csr_pkg::csr_word_t save3_o,
    output csr_pkg::csr_word_t llbctl_o,
    output logic               llbit_o
);

    csr_pkg::csr_word_t save_q [4];
    logic               klo_q;
    logic               llbit_q;

    always_ff @(posedge clk) begin
        case (wr_i.sel)
            csr_pkg::SEL_SAVE0: save_q[0] <= wr_i.data;
            csr_pkg::SEL_SAVE1: save_q[1] <= wr_i.data;
            csr_pkg::SEL_SAVE2: save_q[2] <= wr_i.data;
            csr_pkg::SEL_SAVE3: save_q[3] <= wr_i.data;
            default: ;
        endcase
    end

    // klo keeps llbit alive across a single ertn
    always_ff @(posedge clk) begin
        if (rst) begin
            klo_q   <= 1'b0;
            llbit_q <= 1'b0;
        end else if (ertn_flush_i) begin
            if (klo_q) begin
                klo_q <= 1'b0;
            end else begin
                llbit_q <= 1'b0;
            end
        end else if (wr_i.sel == csr_pkg::SEL_LLBCTL) begin
            klo_q <= wr_i.data[csr_pkg::LLBCTL_KLO_BIT];
            if (wr_i.data[csr_pkg::LLBCTL_WCLLB_BIT]) begin
                llbit_q <= 1'b0;
            end
        end else if (llbit_set_i) begin
            llbit_q <= llbit_i;
        end
    end

    assign save0_o  = save_q[0];
    assign save1_o  = save_q[1];
    assign save2_o  = save_q[2];
    assign save3_o  = save_q[3];
    assign llbctl_o = {29'b0, klo_q, 1'b0, llbit_q};
    assign llbit_o  = llbit_q;

endmodule

// ==== hdl/csr_timer.sv ====
`timescale 1ns/1ns

module csr_timer (
    input  logic               clk,
    input  logic               rst,
    input  csr_pkg::csr_wr_t   wr_i,
    output csr_pkg::csr_word_t tid_o,
    output csr_pkg::csr_word_t tcfg_o,
    output csr_pkg::csr_word_t tval_o,
    output csr_pkg::csr_word_t cntc_o,
    output logic               timer_int_o,
    output logic [63:0]        timer_64_o
);

    csr_pkg::csr_word_t tid_q;
    csr_pkg::csr_word_t tcfg_q;
    csr_pkg::csr_word_t tval_q;
    csr_pkg::csr_word_t cntc_q;
    logic               run_q;
    logic               int_q;
    logic [63:0]        cnt_q;
    logic               expire;
    logic               tcfg_we;
    logic               clr_we;

    assign tcfg_we = (wr_i.sel == csr_pkg::SEL_TCFG);
    assign clr_we  = (wr_i.sel == csr_pkg::SEL_TICLR) && wr_i.data[csr_pkg::TICLR_CLR_BIT];
    assign expire  = run_q && (tval_q == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            tid_q  <= '0;
            tcfg_q <= '0;
            tval_q <= '0;
            cntc_q <= '0;
            run_q  <= 1'b0;
            int_q  <= 1'b0;
            cnt_q  <= '0;
        end else begin
            cnt_q <= cnt_q + 64'd1;
            if (wr_i.sel == csr_pkg::SEL_TID) begin
                tid_q <= wr_i.data;
            end
            if (wr_i.sel == csr_pkg::SEL_CNTC) begin
                cntc_q <= wr_i.data;
            end
            // countdown, initval is scaled by 4
            if (tcfg_we) begin
                tcfg_q <= wr_i.data;
                tval_q <= {wr_i.data[31:csr_pkg::TCFG_INITVAL_LSB],
                           {csr_pkg::TCFG_INITVAL_LSB{1'b0}}};
                run_q  <= wr_i.data[csr_pkg::TCFG_EN_BIT];
            end else if (expire) begin
                if (tcfg_q[csr_pkg::TCFG_PERIODIC_BIT]) begin
                    tval_q <= {tcfg_q[31:csr_pkg::TCFG_INITVAL_LSB],
                               {csr_pkg::TCFG_INITVAL_LSB{1'b0}}};
                end else begin
                    run_q <= 1'b0;
                end
            end else if (run_q) begin
                tval_q <= tval_q - 32'd1;
            end
            // clear wins over a new expiry
            if (clr_we) begin
                int_q <= 1'b0;
            end else if (expire && !tcfg_we) begin
                int_q <= 1'b1;
            end
        end
    end

    assign tid_o       = tid_q;
    assign tcfg_o      = tcfg_q;
    assign tval_o      = tval_q;
    assign cntc_o      = cntc_q;
    assign timer_int_o = int_q;
    assign timer_64_o  = cnt_q + {{32{cntc_q[31]}}, cntc_q};

endmodule

// ==== hdl/csr_trap_regs.sv ====
`timescale 1ns/1ns

module csr_trap_regs (
    input  logic                              clk,
    input  logic                              rst,
    input  csr_pkg::csr_wr_t                  wr_i,
    input  logic                              excp_flush_i,
    input  logic                              ertn_flush_i,
    input  csr_pkg::excp_t                    excp_i,
    input  logic [csr_pkg::HW_INT_WIDTH-1:0]  hw_int_i,
    input  logic                              timer_int_i,
    output logic [1:0]                        plv_o,
    output csr_pkg::csr_word_t                crmd_o,
    output csr_pkg::csr_word_t                prmd_o,
    output csr_pkg::csr_word_t                ectl_o,
    output csr_pkg::csr_word_t                estat_o,
    output csr_pkg::csr_word_t                era_o,
    output csr_pkg::csr_word_t                eentry_o
);

    csr_pkg::crmd_t                           crmd_q;
    csr_pkg::prmd_t                           prmd_q;
    logic [12:0]                              lie_q;
    logic [1:0]                               sw_is_q;
    logic [csr_pkg::HW_INT_WIDTH-1:0]         hw_is_q;
    logic [5:0]                               ecode_q;
    logic [8:0]                               esubcode_q;
    csr_pkg::csr_word_t                       era_q;
    logic [31:csr_pkg::EENTRY_ALIGN_BITS]     eentry_q;
    csr_pkg::estat_t                          estat;

    // crmd and prmd, flushes override software writes
    always_ff @(posedge clk) begin
        if (rst) begin
            crmd_q <= csr_pkg::crmd_t'(csr_pkg::CRMD_RESET[8:0]);
            prmd_q <= '0;
        end else if (excp_flush_i) begin
            prmd_q.pplv <= crmd_q.plv;
            prmd_q.pie  <= crmd_q.ie;
            crmd_q.plv  <= 2'b00;
            crmd_q.ie   <= 1'b0;
        end else if (ertn_flush_i) begin
            crmd_q.plv <= prmd_q.pplv;
            crmd_q.ie  <= prmd_q.pie;
        end else begin
            if (wr_i.sel == csr_pkg::SEL_CRMD) begin
                crmd_q <= csr_pkg::crmd_t'(wr_i.data[8:0]);
            end
            if (wr_i.sel == csr_pkg::SEL_PRMD) begin
                prmd_q <= csr_pkg::prmd_t'(wr_i.data[2:0]);
            end
        end
    end

    // ectl and the writable part of estat
    always_ff @(posedge clk) begin
        if (rst) begin
            lie_q      <= '0;
            sw_is_q    <= '0;
            ecode_q    <= '0;
            esubcode_q <= '0;
        end else begin
            if (wr_i.sel == csr_pkg::SEL_ECTL) begin
                lie_q <= wr_i.data[12:0];
            end
            if (excp_flush_i) begin
                ecode_q    <= excp_i.ecode;
                esubcode_q <= excp_i.esubcode;
            end else if (wr_i.sel == csr_pkg::SEL_ESTAT) begin
                sw_is_q <= wr_i.data[1:0];
            end
        end
    end

    // hw interrupt lines sampled each cycle
    always_ff @(posedge clk) begin
        hw_is_q <= hw_int_i;
    end

    always_ff @(posedge clk) begin
        if (excp_flush_i) begin
            era_q <= excp_i.era;
        end else if (wr_i.sel == csr_pkg::SEL_ERA) begin
            era_q <= wr_i.data;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_i.sel == csr_pkg::SEL_EENTRY) begin
            eentry_q <= wr_i.data[31:csr_pkg::EENTRY_ALIGN_BITS];
        end
    end

    always_comb begin
        estat.is                            = '0;
        estat.is[1:0]                       = sw_is_q;
        estat.is[2 +: csr_pkg::HW_INT_WIDTH] = hw_is_q;
        estat.is[csr_pkg::TIMER_IS_BIT]     = timer_int_i;
        estat.ecode                         = ecode_q;
        estat.esubcode                      = esubcode_q;
    end

    // privilege level seen by the pipeline this cycle
    always_comb begin
        if (excp_flush_i) begin
            plv_o = 2'b00;
        end else if (ertn_flush_i) begin
            plv_o = prmd_q.pplv;
        end else begin
            plv_o = crmd_q.plv;
        end
    end

    assign crmd_o   = {23'b0, crmd_q};
    assign prmd_o   = {29'b0, prmd_q};
    assign ectl_o   = {19'b0, lie_q};
    assign estat_o  = {1'b0, estat.esubcode, estat.ecode, 3'b000, estat.is};
    assign era_o    = era_q;
    assign eentry_o = {eentry_q, {csr_pkg::EENTRY_ALIGN_BITS{1'b0}}};

endmodule

// ==== hdl/csr_write_decode.sv ====
`timescale 1ns/1ns

module csr_write_decode (
    input  csr_pkg::csr_write_t wport1_i,
    input  csr_pkg::csr_write_t wport2_i,
    output csr_pkg::csr_wr_t    wr_o
);

    csr_pkg::csr_write_t act;

    // port 1 wins a same-cycle conflict
    always_comb begin
        if (wport1_i.we) begin
            act = wport1_i;
        end else begin
            act = wport2_i;
        end
    end

    always_comb begin
        wr_o.data = act.data;
        wr_o.sel  = csr_pkg::SEL_NONE;
        if (act.we) begin
            case (act.addr)
                csr_pkg::CSR_CRMD:   wr_o.sel = csr_pkg::SEL_CRMD;
                csr_pkg::CSR_PRMD:   wr_o.sel = csr_pkg::SEL_PRMD;
                csr_pkg::CSR_ECTL:   wr_o.sel = csr_pkg::SEL_ECTL;
                csr_pkg::CSR_ESTAT:  wr_o.sel = csr_pkg::SEL_ESTAT;
                csr_pkg::CSR_ERA:    wr_o.sel = csr_pkg::SEL_ERA;
                csr_pkg::CSR_EENTRY: wr_o.sel = csr_pkg::SEL_EENTRY;
                csr_pkg::CSR_SAVE0:  wr_o.sel = csr_pkg::SEL_SAVE0;
                csr_pkg::CSR_SAVE1:  wr_o.sel = csr_pkg::SEL_SAVE1;
                csr_pkg::CSR_SAVE2:  wr_o.sel = csr_pkg::SEL_SAVE2;
                csr_pkg::CSR_SAVE3:  wr_o.sel = csr_pkg::SEL_SAVE3;
                csr_pkg::CSR_TID:    wr_o.sel = csr_pkg::SEL_TID;
                csr_pkg::CSR_TCFG:   wr_o.sel = csr_pkg::SEL_TCFG;
                csr_pkg::CSR_TVAL:   wr_o.sel = csr_pkg::SEL_TVAL;
                csr_pkg::CSR_CNTC:   wr_o.sel = csr_pkg::SEL_CNTC;
                csr_pkg::CSR_TICLR:  wr_o.sel = csr_pkg::SEL_TICLR;
                csr_pkg::CSR_LLBCTL: wr_o.sel = csr_pkg::SEL_LLBCTL;
                default:             wr_o.sel = csr_pkg::SEL_NONE;
            endcase
        end
    end

endmodule

// ==== verification/csr_file_tb_table.svh ====
// rows are op, address, data, expected
// exception rows carry era in data and {esubcode, ecode} in expected[14:0]
task automatic build_table();
    csr_pkg::csr_word_t vals [4];
    csr_pkg::csr_word_t v;

    // reset state
    add_row(OP_READ, csr_pkg::CSR_CRMD, 32'h0, 32'h0000_0008);
    add_row(OP_FLAG, csr_pkg::CSR_CRMD, FLAG_HAS_INT, 32'h0);
    add_row(OP_FLAG, csr_pkg::CSR_CRMD, FLAG_LLBIT, 32'h0);
    add_row(OP_PLV, csr_pkg::CSR_CRMD, 32'h0, 32'h0);

    // scratch registers on alternating ports
    for (int i = 0; i < 4; i++) begin
        vals[i] = lcg_next();
        add_row((i % 2 == 0) ? OP_WR1 : OP_WR2, save_addr(i), vals[i], 32'h0);
    end
    for (int i = 0; i < 4; i++) begin
        add_row(OP_READ, save_addr(i), 32'h0, vals[i]);
    end

    // port 2 carries the inverted value in a same-cycle conflict
    v = lcg_next();
    add_row(OP_WR_BOTH, csr_pkg::CSR_SAVE2, v, 32'h0);
    add_row(OP_READ, csr_pkg::CSR_SAVE2, 32'h0, v);

    // low 6 bits of eentry are forced to zero
    add_row(OP_WR1, csr_pkg::CSR_EENTRY, 32'h1c00_0abc, 32'h0);
    add_row(OP_READ, csr_pkg::CSR_EENTRY, 32'h0, 32'h1c00_0a80);

    // tid is a plain read/write word
    add_row(OP_WR2, csr_pkg::CSR_TID, 32'h0000_0a5c, 32'h0);
    add_row(OP_READ, csr_pkg::CSR_TID, 32'h0, 32'h0000_0a5c);

    // exception entry from plv 3 with ie set
    add_row(OP_WR1, csr_pkg::CSR_CRMD, 32'h0000_000f, 32'h0);
    add_row(OP_READ, csr_pkg::CSR_CRMD, 32'h0, 32'h0000_000f);
    add_row(OP_EXCP, csr_pkg::CSR_CRMD, 32'h1c00_1234, {17'h0, 9'h001, 6'h0b});
    add_row(OP_READ, csr_pkg::CSR_CRMD, 32'h0, 32'h0000_0008);
    add_row(OP_READ, csr_pkg::CSR_PRMD, 32'h0, 32'h0000_0007);
    add_row(OP_READ, csr_pkg::CSR_ESTAT, 32'h0, 32'h004b_0000);
    add_row(OP_READ, csr_pkg::CSR_ERA, 32'h0, 32'h1c00_1234);
    add_row(OP_ERTN, csr_pkg::CSR_CRMD, 32'h0, 32'h3);
    add_row(OP_READ, csr_pkg::CSR_CRMD, 32'h0, 32'h0000_000f);

    // one-shot timer with initval 3 counts from 12
    add_row(OP_WR1, csr_pkg::CSR_ECTL, 32'h0000_0800, 32'h0);
    add_row(OP_WR2, csr_pkg::CSR_TCFG, 32'h0000_000d, 32'h0);
    add_row(OP_WAIT_INT, csr_pkg::CSR_CRMD, 32'd60, 32'h0);
    add_row(OP_READ, csr_pkg::CSR_ESTAT, 32'h0, 32'h004b_0800);
    add_row(OP_WR1, csr_pkg::CSR_TICLR, 32'h0000_0001, 32'h0);
    add_row(OP_READ, csr_pkg::CSR_ESTAT, 32'h0, 32'h004b_0000);
    add_row(OP_FLAG, csr_pkg::CSR_CRMD, FLAG_HAS_INT, 32'h0);

    // llbit set then cleared by ertn and by wcllb
    add_row(OP_LL_SET, csr_pkg::CSR_CRMD, 32'h1, 32'h0);
    add_row(OP_FLAG, csr_pkg::CSR_CRMD, FLAG_LLBIT, 32'h1);
    add_row(OP_ERTN, csr_pkg::CSR_CRMD, 32'h0, 32'h3);
    add_row(OP_FLAG, csr_pkg::CSR_CRMD, FLAG_LLBIT, 32'h0);
    add_row(OP_LL_SET, csr_pkg::CSR_CRMD, 32'h1, 32'h0);
    add_row(OP_READ, csr_pkg::CSR_LLBCTL, 32'h0, 32'h0000_0001);
    add_row(OP_WR1, csr_pkg::CSR_LLBCTL, 32'h0000_0002, 32'h0);
    add_row(OP_FLAG, csr_pkg::CSR_CRMD, FLAG_LLBIT, 32'h0);

    // stable counter alone and with a cntc offset added mid-window
    add_row(OP_COUNT, csr_pkg::CSR_CNTC, 32'd5, 32'h0);
    add_row(OP_COUNT, csr_pkg::CSR_CNTC, 32'd6, 32'h0000_0100);
    add_row(OP_READ, csr_pkg::CSR_CNTC, 32'h0, 32'h0000_0100);
endtask

// ==== verification/csr_file_tb.sv ====
`timescale 1ns/1ns

module csr_file_tb;

    typedef enum logic [3:0] {
        OP_WR1,
        OP_WR2,
        OP_WR_BOTH,
        OP_READ,
        OP_EXCP,
        OP_ERTN,
        OP_WAIT_INT,
        OP_FLAG,
        OP_PLV,
        OP_LL_SET,
        OP_COUNT
    } op_e;

    typedef struct packed {
        op_e                op;
        csr_pkg::csr_addr_e addr;
        csr_pkg::csr_word_t data;
        csr_pkg::csr_word_t exp;
    } row_t;

    localparam csr_pkg::csr_word_t FLAG_HAS_INT = 32'd0;
    localparam csr_pkg::csr_word_t FLAG_LLBIT   = 32'd1;

    logic                             clk;
    logic                             rst;
    csr_pkg::csr_write_t              wport1;
    csr_pkg::csr_write_t              wport2;
    logic                             excp_flush;
    csr_pkg::excp_t                   excp;
    logic                             ertn_flush;
    logic [csr_pkg::HW_INT_WIDTH-1:0] hw_int;
    logic                             llbit_in;
    logic                             llbit_set;
    csr_pkg::csr_addr_e               raddr;
    csr_pkg::csr_word_t               rdata;
    logic                             has_int;
    logic [1:0]                       plv;
    csr_pkg::csr_word_t               eentry;
    csr_pkg::csr_word_t               era;
    csr_pkg::csr_word_t               tid;
    logic [63:0]                      timer_64;
    logic                             llbit;

    row_t                             rows [$];
    logic [31:0]                      lcg_state = 32'd77441;

    csr_file dut (
        .clk          (clk),
        .rst          (rst),
        .wport1_i     (wport1),
        .wport2_i     (wport2),
        .excp_flush_i (excp_flush),
        .excp_i       (excp),
        .ertn_flush_i (ertn_flush),
        .hw_int_i     (hw_int),
        .llbit_i      (llbit_in),
        .llbit_set_i  (llbit_set),
        .raddr_i      (raddr),
        .rdata_o      (rdata),
        .has_int_o    (has_int),
        .plv_o        (plv),
        .eentry_o     (eentry),
        .era_o        (era),
        .tid_o        (tid),
        .timer_64_o   (timer_64),
        .llbit_o      (llbit)
    );

    always #5 clk = ~clk;

    function automatic csr_pkg::csr_word_t lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic csr_pkg::csr_addr_e save_addr(input int idx);
        return csr_pkg::csr_addr_e'(csr_pkg::CSR_SAVE0 + idx);
    endfunction

    task automatic add_row(input op_e op, input csr_pkg::csr_addr_e addr,
                           input csr_pkg::csr_word_t data, input csr_pkg::csr_word_t exp);
        row_t r;
        r.op   = op;
        r.addr = addr;
        r.data = data;
        r.exp  = exp;
        rows.push_back(r);
    endtask

    `include "csr_file_tb_table.svh"

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_word(input string name, input csr_pkg::csr_word_t got,
                              input csr_pkg::csr_word_t exp);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] %s got 0x%08h expected 0x%08h", name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic check_plv(input string name, input logic [1:0] got, input logic [1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] %s got 0x%016h expected 0x%016h", name, got, exp));
        end
    endtask

    // word outputs that mirror a csr
    task automatic compare_output_ports(input row_t r);
        case (r.addr)
            csr_pkg::CSR_EENTRY: check_word("eentry_o", eentry, r.exp);
            csr_pkg::CSR_ERA:    check_word("era_o", era, r.exp);
            csr_pkg::CSR_TID:    check_word("tid_o", tid, r.exp);
            default: ;
        endcase
    endtask

    // one write cycle on either or both ports
    task automatic write_cycle(input row_t r);
        csr_pkg::csr_write_t w;
        w.we   = 1'b1;
        w.addr = r.addr;
        w.data = r.data;
        @(posedge clk);
        if (r.op != OP_WR2) begin
            wport1 <= w;
        end
        if (r.op == OP_WR_BOTH) begin
            w.data = ~r.data;
        end
        if (r.op != OP_WR1) begin
            wport2 <= w;
        end
        @(posedge clk);
        wport1.we <= 1'b0;
        wport2.we <= 1'b0;
        @(negedge clk);
    endtask

    task automatic pulse_exception(input row_t r);
        @(posedge clk);
        excp_flush    <= 1'b1;
        excp.ecode    <= r.exp[5:0];
        excp.esubcode <= r.exp[14:6];
        excp.era      <= r.data;
        @(negedge clk);
        check_plv("plv_o during excp_flush", plv, 2'b00);
        @(posedge clk);
        excp_flush <= 1'b0;
        @(negedge clk);
        check_word("era_o", era, r.data);
    endtask

    task automatic pulse_return(input row_t r);
        @(posedge clk);
        ertn_flush <= 1'b1;
        @(negedge clk);
        check_plv("plv_o during ertn_flush", plv, r.exp[1:0]);
        @(posedge clk);
        ertn_flush <= 1'b0;
        @(negedge clk);
    endtask

    task automatic wait_interrupt(input int limit);
        int n;
        n = 0;
        while (has_int !== 1'b1) begin
            if (n == limit) begin
                abort_run("timed out waiting for has_int_o to rise");
            end
            @(negedge clk);
            n++;
        end
    endtask

    // counter delta over n cycles with an optional cntc write in the window
    task automatic count_window(input row_t r);
        logic [63:0] t0;
        logic [63:0] t1;
        csr_pkg::csr_write_t w;
        w.we   = 1'b1;
        w.addr = csr_pkg::CSR_CNTC;
        w.data = r.exp;
        t0 = timer_64;
        for (int i = 0; i < r.data; i++) begin
            @(posedge clk);
            if (i == 0 && r.exp != '0) begin
                wport1 <= w;
            end
            if (i == 1) begin
                wport1.we <= 1'b0;
            end
        end
        @(negedge clk);
        t1 = timer_64;
        check_count("timer_64_o delta", t1 - t0, 64'(r.data) + {{32{r.exp[31]}}, r.exp});
    endtask

    task automatic apply_row(input row_t r);
        case (r.op)
            OP_WR1, OP_WR2, OP_WR_BOTH: write_cycle(r);
            OP_READ: begin
                @(posedge clk);
                raddr <= r.addr;
                @(negedge clk);
                check_word($sformatf("rdata_o at %s", r.addr.name()), rdata, r.exp);
                compare_output_ports(r);
            end
            OP_EXCP:     pulse_exception(r);
            OP_ERTN:     pulse_return(r);
            OP_WAIT_INT: wait_interrupt(int'(r.data));
            OP_FLAG: begin
                if (r.data == FLAG_HAS_INT) begin
                    check_bit("has_int_o", has_int, r.exp[0]);
                end else begin
                    check_bit("llbit_o", llbit, r.exp[0]);
                end
            end
            OP_PLV:      check_plv("plv_o", plv, r.exp[1:0]);
            OP_LL_SET: begin
                @(posedge clk);
                llbit_set <= 1'b1;
                llbit_in  <= r.data[0];
                @(posedge clk);
                llbit_set <= 1'b0;
                llbit_in  <= 1'b0;
                @(negedge clk);
            end
            OP_COUNT:    count_window(r);
            default:     abort_run("table row holds an unknown operation");
        endcase
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        wport1     = '0;
        wport2     = '0;
        excp_flush = 1'b0;
        excp       = '0;
        ertn_flush = 1'b0;
        hw_int     = '0;
        llbit_in   = 1'b0;
        llbit_set  = 1'b0;
        raddr      = csr_pkg::CSR_CRMD;
        build_table();
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        foreach (rows[i]) begin
            apply_row(rows[i]);
        end
        $display("All checks passed");
        $finish;
    end

endmodule
